// File: include/numbat_defines.svh
/* widths and register map of the chess accelerator control block,
   included by every file that decodes a control address */
`ifndef NUMBAT_DEFINES_SVH
`define NUMBAT_DEFINES_SVH

`define BOARD_WIDTH 256
`define CTRL_ADDR_WIDTH 18
`define CTRL_REG_WIDTH 14 // address without its low 4 bits
`define CTRL_DATA_WIDTH 128
`define CTRL_BE_WIDTH 16
`define MOVE_INDEX_WIDTH 8
`define HALF_MOVE_WIDTH 7
`define EVAL_WIDTH 24
`define TRANS_DEPTH_WIDTH 8
`define TRANS_NODES_WIDTH 28
`define TRANS_HASH_WIDTH 80

`define REG_CTRL 14'd0
`define REG_MOVE_INDEX 14'd1
`define REG_POSITION 14'd2
`define REG_HALF_MOVE 14'd3
`define REG_QUIESCENCE 14'd4
`define REG_BOARD_LO 14'd8
`define REG_BOARD_HI 14'd9
`define REG_MG_STATUS 14'd132
`define REG_MOVE_COUNT 14'd135
`define REG_ROOT_EVAL 14'd136

`define TRANS_OFS_STATUS 0
`define TRANS_OFS_IDLE 1
`define TRANS_OFS_ENTRY 8
`define TRANS_OFS_CMD 9
`define TRANS_OFS_HASH_LO 10
`define TRANS_OFS_HASH_MID 11
`define TRANS_OFS_HASH_HI 12

`define TRANS_BASE_MAIN 512
`define TRANS_BASE_QUIESCE 612

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the control block simulation with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sim.f \
   --top-module numbat_ctrl_tb -o numbat_ctrl_sim > build.log 2>&1 &&
./obj_dir/numbat_ctrl_sim > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; } ||
{ echo "PASS"; exit 0; }

// File: sim.f
+incdir+include
verilog/numbat_ctrl_pkg.sv
verilog/board_setup_regs.sv
verilog/trans_port.sv
verilog/ctrl_readback.sv
verilog/numbat_ctrl_top.sv
tests/numbat_ctrl_tb.sv

// File: tests/numbat_ctrl_tb.sv
/* testbench for the control register block: LFSR driven bus traffic against
   a register model, checked by concurrent assertions */
`timescale 1ns/100ps
`default_nettype none

`include "numbat_defines.svh"

module numbat_ctrl_tb;
   import numbat_ctrl_pkg::*;

   localparam int STIM_CYCLES = 434;
   localparam int CYCLE_LIMIT = 4 * STIM_CYCLES + 100;
   localparam int MAIN_ENTRY = `TRANS_BASE_MAIN + `TRANS_OFS_ENTRY;
   localparam int MAIN_CMD = `TRANS_BASE_MAIN + `TRANS_OFS_CMD;
   localparam int Q_ENTRY = `TRANS_BASE_QUIESCE + `TRANS_OFS_ENTRY;
   localparam int Q_CMD = `TRANS_BASE_QUIESCE + `TRANS_OFS_CMD;
   localparam int READABLE [18] = '{0, 1, 2, 3, 4, 132, 135, 136, 512, 513, 522, 523, 524,
                                    612, 613, 622, 623, 624};

   logic                         clk;
   logic                         arst_n;
   ctrl_bus_t                    bus;
   logic [`CTRL_DATA_WIDTH-1:0]  dout;
   logic [`BOARD_WIDTH-1:0]      board;
   position_t                    position;
   logic                         new_board_valid;
   logic                         clear_moves;
   logic                         soft_reset;
   logic                         quiescence_moves;
   logic [`MOVE_INDEX_WIDTH-1:0] move_index;
   logic [`HALF_MOVE_WIDTH-1:0]  half_move;
   mg_status_t                   mg_status;
   root_status_t                 root_status;
   trans_req_t                   trans_req;
   trans_req_t                   q_trans_req;
   trans_rsp_t                   trans_rsp;
   trans_rsp_t                   q_trans_rsp;

   // register model
   logic [`BOARD_WIDTH-1:0]      exp_board;
   logic [8:0]                   exp_position;
   logic                         exp_nbv;
   logic                         exp_clear;
   logic                         exp_soft;
   logic                         exp_quiesce;
   logic [7:0]                   exp_move_index;
   logic [6:0]                   exp_half_move;
   logic [63:0]                  exp_entry;
   logic [63:0]                  exp_q_entry;
   logic [3:0]                   exp_cmd;
   logic [3:0]                   exp_q_cmd;
   logic [127:0]                 exp_dout;

   logic [31:0]                  lfsr;
   int                           error_count = 0;
   int                           cycle_count = 0;

   numbat_ctrl_top DUT (
      .clk (clk), .arst_n (arst_n), .bus (bus), .dout (dout), .board (board),
      .position (position), .new_board_valid (new_board_valid),
      .clear_moves (clear_moves), .soft_reset (soft_reset),
      .quiescence_moves (quiescence_moves), .move_index (move_index),
      .half_move (half_move), .mg_status (mg_status), .root_status (root_status),
      .trans_req (trans_req), .q_trans_req (q_trans_req),
      .trans_rsp (trans_rsp), .q_trans_rsp (q_trans_rsp)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [159:0] rand_bits(input int n);
      logic [159:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_next(lfsr);
         v = {v[158:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [127:0] merge_bytes(input logic [127:0] old,
                                                input logic [127:0] din,
                                                input logic [15:0] we);
      logic [127:0] r;
      r = old;
      for (int i = 0; i < 16; i++)
         if (we[i])
            r[i*8 +: 8] = din[i*8 +: 8];
      return r;
   endfunction

   function automatic logic [127:0] trans_read(input logic [13:0] idx, input int base,
                                               input trans_rsp_t rsp);
      logic [127:0] r;
      r = '0;
      case (int'(idx) - base)
         0: r[63:0] = rsp.status;
         1: r[1:0] = {rsp.capture, rsp.idle};
         10: r[31:0] = rsp.hash[31:0];
         11: r[31:0] = rsp.hash[63:32];
         12: r[15:0] = rsp.hash[79:64];
         default: ;
      endcase
      return r;
   endfunction

   function automatic logic [127:0] read_model(input logic [17:0] addr);
      logic [127:0] r;
      r = '0;
      case (addr[17:4])
         `REG_CTRL: r[31:0] = {exp_soft, 20'd0, root_status.board_check,
                               root_status.insufficient_material, root_status.fifty_move,
                               mg_status.idle, root_status.thrice_rep, root_status.mate,
                               root_status.stalemate, mg_status.move_ready,
                               mg_status.moves_ready, exp_clear, exp_nbv};
         `REG_MOVE_INDEX: r[7:0] = exp_move_index;
         `REG_POSITION: r[8:0] = exp_position;
         `REG_HALF_MOVE: r[6:0] = exp_half_move;
         `REG_QUIESCENCE: r[0] = exp_quiesce;
         `REG_MG_STATUS: r[25:0] = {mg_status.eval, mg_status.check, mg_status.capture};
         `REG_MOVE_COUNT: r[7:0] = mg_status.move_count;
         `REG_ROOT_EVAL: r[23:0] = root_status.eval;
         default: r = trans_read(addr[17:4], `TRANS_BASE_MAIN, trans_rsp)
                    | trans_read(addr[17:4], `TRANS_BASE_QUIESCE, q_trans_rsp);
      endcase
      return r;
   endfunction

   // entry field positions of the 64-bit table word
   function automatic logic entry_decodes(input trans_entry_t e, input logic [63:0] w);
      return e.eval == w[23:0] && e.depth == w[31:24] && e.nodes == w[59:32]
             && e.flag == w[62:61] && e.capture == w[63];
   endfunction

   always @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         exp_board <= '0;
         exp_position <= '0;
         {exp_nbv, exp_clear, exp_soft, exp_quiesce} <= '0;
         exp_move_index <= '0;
         exp_half_move <= '0;
         exp_entry <= '0;
         exp_q_entry <= '0;
         exp_cmd <= '0;
         exp_q_cmd <= '0;
         exp_dout <= '0;
      end
      else
      begin
         exp_cmd <= '0;
         exp_q_cmd <= '0;
         exp_dout <= read_model(bus.addr);
         if (bus.en && bus.we != '0)
         begin
            case (int'(bus.addr[17:4]))
               `REG_CTRL: {exp_soft, exp_clear, exp_nbv} <= {bus.din[31], bus.din[1:0]};
               `REG_MOVE_INDEX: exp_move_index <= bus.din[7:0];
               `REG_POSITION: exp_position <= bus.din[8:0];
               `REG_HALF_MOVE: exp_half_move <= bus.din[6:0];
               `REG_QUIESCENCE: exp_quiesce <= bus.din[0];
               `REG_BOARD_LO: exp_board[127:0] <= merge_bytes(exp_board[127:0], bus.din,
                                                              bus.we);
               `REG_BOARD_HI: exp_board[255:128] <= merge_bytes(exp_board[255:128], bus.din,
                                                                bus.we);
               MAIN_ENTRY: exp_entry <= bus.din[63:0];
               MAIN_CMD: exp_cmd <= bus.din[3:0];
               Q_ENTRY: exp_q_entry <= bus.din[63:0];
               Q_CMD: exp_q_cmd <= bus.din[3:0];
               default: ;
            endcase
         end
      end
   end

   task automatic flag_error(input string msg);
      error_count++;
      $display("** Error at %0t: %s", $time, msg);
   endtask

   a_reset_values: assert property (@(posedge clk) $rose(arst_n) |->
      (dout == '0 && board == '0 && position == '0 && !new_board_valid && !clear_moves
       && !soft_reset && !quiescence_moves && move_index == '0 && half_move == '0
       && trans_req == '0 && q_trans_req == '0))
      else flag_error("outputs not cleared by reset");
   a_ctrl_bits: assert property (@(posedge clk) disable iff (!arst_n)
      {new_board_valid, clear_moves, soft_reset, quiescence_moves}
      == {exp_nbv, exp_clear, exp_soft, exp_quiesce})
      else flag_error("control bits differ from the model");
   a_setup_regs: assert property (@(posedge clk) disable iff (!arst_n)
      position == exp_position && move_index == exp_move_index
      && half_move == exp_half_move)
      else flag_error("position, move index or half move differs from the model");
   a_board: assert property (@(posedge clk) disable iff (!arst_n) board == exp_board)
      else flag_error("board differs from the model");
   a_main_req: assert property (@(posedge clk) disable iff (!arst_n)
      trans_req == {exp_entry, exp_cmd} && entry_decodes(trans_req.entry, exp_entry))
      else flag_error("main table request differs from the model");
   a_q_req: assert property (@(posedge clk) disable iff (!arst_n)
      q_trans_req == {exp_q_entry, exp_q_cmd} && entry_decodes(q_trans_req.entry, exp_q_entry))
      else flag_error("quiescence table request differs from the model");
   a_dout: assert property (@(posedge clk) disable iff (!arst_n) dout == exp_dout)
      else flag_error("dout differs from the expected read data");

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT)
      begin
         $display("timeout: stimulus still running after %0d cycles", cycle_count);
         $display("Test failures found");
         $finish;
      end
   end

   // one bus cycle with random low address bits
   task automatic drive_bus(input int idx, input logic [127:0] din, input logic [15:0] we,
                            input logic en);
      logic [159:0] lo;
      lo = rand_bits(4);
      bus.addr = {14'(idx), lo[3:0]};
      bus.din = din;
      bus.we = we;
      bus.en = en;
      @(negedge clk);
   endtask

   task automatic drive_read(input int idx);
      drive_bus(idx, 128'(rand_bits(128)), 16'(rand_bits(16)), 1'b0);
   endtask

   initial
   begin
      logic [159:0] v;
      int           idx;
      int           base;
      bus = '0;
      mg_status = '0;
      root_status = '0;
      trans_rsp = '0;
      q_trans_rsp = '0;
      arst_n = 1'b0;
      lfsr = 32'h9aad_10a3;
      repeat (4) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      repeat (60)
      begin
         v = rand_bits(3);
         idx = int'(v[2:0]) % 5;
         drive_bus(idx, 128'(rand_bits(128)), 16'(rand_bits(16)), rand_bits(3) != 0);
         drive_read(idx);
      end
      repeat (40)
      begin
         v = rand_bits(1);
         idx = `REG_BOARD_LO + int'(v[0]);
         drive_bus(idx, 128'(rand_bits(128)), 16'(rand_bits(16)), 1'b1);
         drive_read(idx); // board is write only
      end
      for (int p = 0; p < 2; p++)
      begin
         base = (p == 0) ? `TRANS_BASE_MAIN : `TRANS_BASE_QUIESCE;
         repeat (20)
         begin
            drive_bus(base + `TRANS_OFS_ENTRY, 128'(rand_bits(128)), 16'hffff, 1'b1);
            drive_bus(base + `TRANS_OFS_CMD, 128'(rand_bits(4)), 16'(rand_bits(16)), 1'b1);
            v = rand_bits(2);
            if (v[1:0] == 2'd0)
               drive_bus(base + `TRANS_OFS_CMD, 128'(rand_bits(4)), 16'hffff, 1'b1);
            else
               drive_read(base + `TRANS_OFS_CMD);
            drive_read(base + `TRANS_OFS_STATUS);
         end
      end
      bus = '0;
      arst_n = 1'b0; // reset again with registers and entries loaded
      repeat (4) @(negedge clk);
      arst_n = 1'b1;
      repeat (40)
      begin
         mg_status = mg_status_t'(rand_bits($bits(mg_status_t)));
         root_status = root_status_t'(rand_bits($bits(root_status_t)));
         trans_rsp = trans_rsp_t'(rand_bits($bits(trans_rsp_t)));
         q_trans_rsp = trans_rsp_t'(rand_bits($bits(trans_rsp_t)));
         v = rand_bits(5);
         drive_read(READABLE[int'(v[4:0]) % 18]);
      end
      repeat (20)
      begin
         v = rand_bits(14);
         drive_read(int'(v[13:0])); // mostly unmapped
      end
      bus = '0;
      repeat (2) @(negedge clk);
      $display("run complete: %0d errors in %0d cycles", error_count, cycle_count);
      if (error_count == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog/board_setup_regs.sv
/* board setup registers written by the host before a search, plus the
   move generator and root node status readback */
`timescale 1ns/100ps
`default_nettype none

`include "numbat_defines.svh"

module board_setup_regs (
   input  logic                                clk,
   input  logic                                arst_n,
   input  numbat_ctrl_pkg::ctrl_bus_t          bus,
   output logic [`BOARD_WIDTH-1:0]             board,
   output numbat_ctrl_pkg::position_t          position,
   output logic                                new_board_valid,
   output logic                                clear_moves,
   output logic                                soft_reset,
   output logic                                quiescence_moves,
   output logic [`MOVE_INDEX_WIDTH-1:0]        move_index,
   output logic [`HALF_MOVE_WIDTH-1:0]         half_move,
   input  numbat_ctrl_pkg::mg_status_t         mg_status,
   input  numbat_ctrl_pkg::root_status_t       root_status,
   output logic [`CTRL_DATA_WIDTH-1:0]         rd_data,
   output logic                                rd_hit
);
   import numbat_ctrl_pkg::*;

   localparam int HALF_WIDTH = `BOARD_WIDTH / 2;

   logic [`CTRL_REG_WIDTH-1:0] reg_idx;
   logic                       wr;
   logic                       ctrl_wr;

   assign reg_idx = bus.addr[`CTRL_ADDR_WIDTH-1:4];
   assign wr = bus.en && (|bus.we);
   assign ctrl_wr = wr && (reg_idx == `REG_CTRL);

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         board <= '0;
         position <= '0;
         new_board_valid <= 1'b0;
         clear_moves <= 1'b0;
         soft_reset <= 1'b0;
         quiescence_moves <= 1'b0;
         move_index <= '0;
         half_move <= '0;
      end
      else if (wr)
      begin
         case (reg_idx)
            `REG_CTRL:
            begin
               new_board_valid <= bus.din[0];
               clear_moves <= bus.din[1];
               soft_reset <= bus.din[31];
            end
            `REG_MOVE_INDEX: move_index <= bus.din[`MOVE_INDEX_WIDTH-1:0];
            `REG_POSITION: position <= position_t'(bus.din[$bits(position_t)-1:0]);
            `REG_HALF_MOVE: half_move <= bus.din[`HALF_MOVE_WIDTH-1:0];
            `REG_QUIESCENCE: quiescence_moves <= bus.din[0];
            `REG_BOARD_LO:
               for (int i = 0; i < `CTRL_BE_WIDTH; i++)
                  if (bus.we[i])
                     board[i*8 +: 8] <= bus.din[i*8 +: 8];
            `REG_BOARD_HI:
               for (int i = 0; i < `CTRL_BE_WIDTH; i++)
                  if (bus.we[i])
                     board[HALF_WIDTH + i*8 +: 8] <= bus.din[i*8 +: 8];
            default: ;
         endcase
      end
   end

   always_comb
   begin
      rd_data = '0;
      rd_hit = 1'b1;
      case (reg_idx)
         `REG_CTRL:
         begin
            rd_data[0] = new_board_valid;
            rd_data[1] = clear_moves;
            rd_data[2] = mg_status.moves_ready;
            rd_data[3] = mg_status.move_ready;
            rd_data[4] = root_status.stalemate;
            rd_data[5] = root_status.mate;
            rd_data[6] = root_status.thrice_rep;
            rd_data[7] = mg_status.idle;
            rd_data[8] = root_status.fifty_move;
            rd_data[9] = root_status.insufficient_material;
            rd_data[10] = root_status.board_check;
            rd_data[31] = soft_reset;
         end
         `REG_MOVE_INDEX: rd_data[`MOVE_INDEX_WIDTH-1:0] = move_index;
         `REG_POSITION: rd_data[$bits(position_t)-1:0] = position;
         `REG_HALF_MOVE: rd_data[`HALF_MOVE_WIDTH-1:0] = half_move;
         `REG_QUIESCENCE: rd_data[0] = quiescence_moves;
         // capture in bit 0, check in 1, move eval above
         `REG_MG_STATUS: rd_data[`EVAL_WIDTH+1:0] = {mg_status.eval, mg_status.check,
                                                     mg_status.capture};
         `REG_MOVE_COUNT: rd_data[`MOVE_INDEX_WIDTH-1:0] = mg_status.move_count;
         `REG_ROOT_EVAL: rd_data[`EVAL_WIDTH-1:0] = root_status.eval;
         default: rd_hit = 1'b0; // board halves are write only
      endcase
   end

   a_soft_reset_by_write: assert property (@(posedge clk) disable iff (!arst_n)
      $changed(soft_reset) |-> $past(ctrl_wr));

endmodule

`default_nettype wire

// File: verilog/ctrl_readback.sv
/* registers the read word of whichever register block decodes the address,
   zero when no block claims it */
`timescale 1ns/100ps
`default_nettype none

`include "numbat_defines.svh"

module ctrl_readback (
   input  logic                        clk,
   input  logic                        arst_n,
   input  logic [`CTRL_DATA_WIDTH-1:0] board_rd_data,
   input  logic [`CTRL_DATA_WIDTH-1:0] trans_rd_data,
   input  logic [`CTRL_DATA_WIDTH-1:0] q_trans_rd_data,
   input  logic                        board_rd_hit,
   input  logic                        trans_rd_hit,
   input  logic                        q_trans_rd_hit,
   output logic [`CTRL_DATA_WIDTH-1:0] dout
);

   logic [`CTRL_DATA_WIDTH-1:0] rd_sel;

   // and-or select, hits are one hot
   assign rd_sel = ({`CTRL_DATA_WIDTH{board_rd_hit}} & board_rd_data)
                 | ({`CTRL_DATA_WIDTH{trans_rd_hit}} & trans_rd_data)
                 | ({`CTRL_DATA_WIDTH{q_trans_rd_hit}} & q_trans_rd_data);

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         dout <= '0;
      else
         dout <= rd_sel; // one cycle read latency
   end

   a_one_hit: assert property (@(posedge clk) disable iff (!arst_n)
      $onehot0({board_rd_hit, trans_rd_hit, q_trans_rd_hit}));

endmodule

`default_nettype wire

// File: verilog/numbat_ctrl_pkg.sv
/* bus, status and transposition table types shared by the control block */
`default_nettype none

`include "numbat_defines.svh"

package numbat_ctrl_pkg;

   typedef struct packed {
      logic [`CTRL_ADDR_WIDTH-1:0] addr;
      logic [`CTRL_DATA_WIDTH-1:0] din;
      logic                        en;
      logic [`CTRL_BE_WIDTH-1:0]   we; // byte enables
   } ctrl_bus_t;

   typedef struct packed {
      logic       white_to_move;
      logic [3:0] castle_mask;
      logic [3:0] en_passant_col;
   } position_t;

   typedef struct packed {
      logic                          idle;
      logic                          moves_ready; // all moves generated
      logic                          move_ready;  // indexed move valid
      logic [`MOVE_INDEX_WIDTH-1:0]  move_count;
      logic                          check;
      logic                          capture;
      logic signed [`EVAL_WIDTH-1:0] eval; // of the indexed move
   } mg_status_t;

   typedef struct packed {
      logic                          mate;
      logic                          stalemate;
      logic                          thrice_rep;
      logic                          fifty_move;
      logic                          insufficient_material;
      logic                          board_check;
      logic signed [`EVAL_WIDTH-1:0] eval;
   } root_status_t;

   // store view of the 64-bit entry word
   typedef struct packed {
      logic                          capture;
      logic [1:0]                    flag;
      logic                          unused;
      logic [`TRANS_NODES_WIDTH-1:0] nodes;
      logic [`TRANS_DEPTH_WIDTH-1:0] depth;
      logic signed [`EVAL_WIDTH-1:0] eval;
   } trans_entry_t;

   // lookup view of the same word
   typedef struct packed {
      logic                          collision;
      logic [1:0]                    flag;
      logic                          entry_valid;
      logic [`TRANS_NODES_WIDTH-1:0] nodes;
      logic [`TRANS_DEPTH_WIDTH-1:0] depth;
      logic signed [`EVAL_WIDTH-1:0] eval;
   } trans_status_t;

   typedef union packed {
      trans_entry_t  entry;
      trans_status_t status;
   } trans_word_u;

   typedef struct packed {
      logic clear;
      logic hash_only;
      logic store;
      logic lookup;
   } trans_cmd_t;

   typedef struct packed {
      trans_entry_t entry;
      trans_cmd_t   cmd;
   } trans_req_t;

   typedef struct packed {
      trans_status_t                status;
      logic                         capture;
      logic                         idle;
      logic [`TRANS_HASH_WIDTH-1:0] hash;
   } trans_rsp_t;

endpackage

`default_nettype wire

// File: verilog/numbat_ctrl_top.sv
/* control register block of the search accelerator; the host bus enters here,
   board setup goes to the move generator and both table ports to their tables */
`timescale 1ns/100ps
`default_nettype none

`include "numbat_defines.svh"

module numbat_ctrl_top (
   input  logic                          clk,
   input  logic                          arst_n,
   input  numbat_ctrl_pkg::ctrl_bus_t    bus,
   output logic [`CTRL_DATA_WIDTH-1:0]   dout,
   output logic [`BOARD_WIDTH-1:0]       board,
   output numbat_ctrl_pkg::position_t    position,
   output logic                          new_board_valid,
   output logic                          clear_moves,
   output logic                          soft_reset,
   output logic                          quiescence_moves,
   output logic [`MOVE_INDEX_WIDTH-1:0]  move_index,
   output logic [`HALF_MOVE_WIDTH-1:0]   half_move,
   input  numbat_ctrl_pkg::mg_status_t   mg_status,
   input  numbat_ctrl_pkg::root_status_t root_status,
   output numbat_ctrl_pkg::trans_req_t   trans_req,
   output numbat_ctrl_pkg::trans_req_t   q_trans_req,
   input  numbat_ctrl_pkg::trans_rsp_t   trans_rsp,
   input  numbat_ctrl_pkg::trans_rsp_t   q_trans_rsp
);

   logic [`CTRL_DATA_WIDTH-1:0] board_rd_data;
   logic [`CTRL_DATA_WIDTH-1:0] trans_rd_data;
   logic [`CTRL_DATA_WIDTH-1:0] q_trans_rd_data;
   logic                        board_rd_hit;
   logic                        trans_rd_hit;
   logic                        q_trans_rd_hit;

   board_setup_regs u_board_setup_regs (
      .clk              (clk),
      .arst_n           (arst_n),
      .bus              (bus),
      .board            (board),
      .position         (position),
      .new_board_valid  (new_board_valid),
      .clear_moves      (clear_moves),
      .soft_reset       (soft_reset),
      .quiescence_moves (quiescence_moves),
      .move_index       (move_index),
      .half_move        (half_move),
      .mg_status        (mg_status),
      .root_status      (root_status),
      .rd_data          (board_rd_data),
      .rd_hit           (board_rd_hit)
   );

   trans_port #(.REG_BASE(`TRANS_BASE_MAIN)) u_trans_port (
      .clk     (clk),
      .arst_n  (arst_n),
      .bus     (bus),
      .req     (trans_req),
      .rsp     (trans_rsp),
      .rd_data (trans_rd_data),
      .rd_hit  (trans_rd_hit)
   );

   trans_port #(.REG_BASE(`TRANS_BASE_QUIESCE)) u_q_trans_port (
      .clk     (clk),
      .arst_n  (arst_n),
      .bus     (bus),
      .req     (q_trans_req),
      .rsp     (q_trans_rsp),
      .rd_data (q_trans_rd_data),
      .rd_hit  (q_trans_rd_hit)
   );

   ctrl_readback u_ctrl_readback (
      .clk             (clk),
      .arst_n          (arst_n),
      .board_rd_data   (board_rd_data),
      .trans_rd_data   (trans_rd_data),
      .q_trans_rd_data (q_trans_rd_data),
      .board_rd_hit    (board_rd_hit),
      .trans_rd_hit    (trans_rd_hit),
      .q_trans_rd_hit  (q_trans_rd_hit),
      .dout            (dout)
   );

endmodule

`default_nettype wire

// File: verilog/trans_port.sv
/* host port of one transposition table: entry word, one-cycle commands and
   status readback at REG_BASE */
`timescale 1ns/100ps
`default_nettype none

`include "numbat_defines.svh"

module trans_port #(
   parameter int REG_BASE = `TRANS_BASE_MAIN
) (
   input  logic                        clk,
   input  logic                        arst_n,
   input  numbat_ctrl_pkg::ctrl_bus_t  bus,
   output numbat_ctrl_pkg::trans_req_t req,
   input  numbat_ctrl_pkg::trans_rsp_t rsp,
   output logic [`CTRL_DATA_WIDTH-1:0] rd_data,
   output logic                        rd_hit
);
   import numbat_ctrl_pkg::*;

   localparam logic [`CTRL_REG_WIDTH-1:0] IDX_STATUS =
      `CTRL_REG_WIDTH'(REG_BASE + `TRANS_OFS_STATUS);
   localparam logic [`CTRL_REG_WIDTH-1:0] IDX_IDLE =
      `CTRL_REG_WIDTH'(REG_BASE + `TRANS_OFS_IDLE);
   localparam logic [`CTRL_REG_WIDTH-1:0] IDX_ENTRY =
      `CTRL_REG_WIDTH'(REG_BASE + `TRANS_OFS_ENTRY);
   localparam logic [`CTRL_REG_WIDTH-1:0] IDX_CMD =
      `CTRL_REG_WIDTH'(REG_BASE + `TRANS_OFS_CMD);
   localparam logic [`CTRL_REG_WIDTH-1:0] IDX_HASH_LO =
      `CTRL_REG_WIDTH'(REG_BASE + `TRANS_OFS_HASH_LO);
   localparam logic [`CTRL_REG_WIDTH-1:0] IDX_HASH_MID =
      `CTRL_REG_WIDTH'(REG_BASE + `TRANS_OFS_HASH_MID);
   localparam logic [`CTRL_REG_WIDTH-1:0] IDX_HASH_HI =
      `CTRL_REG_WIDTH'(REG_BASE + `TRANS_OFS_HASH_HI);

   logic [`CTRL_REG_WIDTH-1:0] reg_idx;
   logic                       wr;
   logic                       entry_wr;
   logic                       cmd_wr;
   trans_word_u                wr_word;
   trans_word_u                rd_word;
   logic [3:0]                 cmd_bits;

   assign reg_idx = bus.addr[`CTRL_ADDR_WIDTH-1:4];
   assign wr = bus.en && (|bus.we);
   assign entry_wr = wr && (reg_idx == IDX_ENTRY);
   assign cmd_wr = wr && (reg_idx == IDX_CMD);
   assign wr_word = bus.din[$bits(trans_word_u)-1:0];
   assign cmd_bits = req.cmd;

   always_comb
   begin
      rd_word.status = rsp.status;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         req <= '0;
      else
      begin
         req.cmd <= '0; // commands last one cycle
         if (entry_wr)
            req.entry <= wr_word.entry;
         if (cmd_wr)
            req.cmd <= trans_cmd_t'(bus.din[3:0]);
      end
   end

   always_comb
   begin
      rd_data = '0;
      rd_hit = 1'b1;
      case (reg_idx)
         IDX_STATUS: rd_data[$bits(trans_word_u)-1:0] = rd_word;
         IDX_IDLE: rd_data[1:0] = {rsp.capture, rsp.idle};
         IDX_HASH_LO: rd_data[31:0] = rsp.hash[31:0];
         IDX_HASH_MID: rd_data[31:0] = rsp.hash[63:32];
         IDX_HASH_HI: rd_data[`TRANS_HASH_WIDTH-65:0] = rsp.hash[`TRANS_HASH_WIDTH-1:64];
         default: rd_hit = 1'b0; // entry and command are write only
      endcase
   end

   a_cmd_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
      (|(cmd_bits & $past(cmd_bits))) |-> $past(cmd_wr));

endmodule

`default_nettype wire
